//--- common/icache_pkg.sv
`default_nettype none

package icache_pkg;

	// Cache geometry
	localparam int ADDR_W = 32;
	localparam int NUM_WAYS = 4;
	localparam int NUM_SETS = 16;
	localparam int LINE_BYTES = 16;

	// Address split: tag | index | offset
	localparam int OFFSET_W = $clog2(LINE_BYTES);
	localparam int INDEX_W = $clog2(NUM_SETS);
	localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

	localparam int WORDS_PER_LINE = LINE_BYTES / 4;
	localparam int BEATS_PER_LINE = LINE_BYTES / 8;

	typedef struct packed {
		logic [ADDR_W-1:0] pc;
	} fetch_req_t;

	typedef struct packed {
		logic [ADDR_W-1:0] pc;
		logic [31:0]       inst;
	} fetch_resp_t;

	// Same line seen as instructions or as bus beats, low address in low bits
	typedef union packed {
		logic [WORDS_PER_LINE-1:0][31:0]                         words;
		logic [BEATS_PER_LINE-1:0][LINE_BYTES*8/BEATS_PER_LINE-1:0] beats;
	} cache_line_u;

	typedef struct packed {
		logic [INDEX_W-1:0] index;
		logic [TAG_W-1:0]   tag;
		logic               rd;
		logic               invalidate_all;
		cache_line_u        line;
	} way_cmd_t;

endpackage

`default_nettype wire

//--- common/axi_lite_pkg.sv
`default_nettype none

package axi_lite_pkg;

	localparam int AXI_ADDR_W = 32;
	localparam int AXI_DATA_W = 64;
	localparam int AXI_PROT_W = 3;
	localparam int AXI_RESP_W = 2;

	// Unprivileged, secure, instruction access
	localparam logic [AXI_PROT_W-1:0] PROT_INST = 3'b100;

	// Read address channel payload
	typedef struct packed {
		logic [AXI_ADDR_W-1:0] addr;
		logic [AXI_PROT_W-1:0] prot;
	} axi_ar_t;

	// Read data channel payload
	typedef struct packed {
		logic [AXI_DATA_W-1:0] data;
		logic [AXI_RESP_W-1:0] resp;
	} axi_r_t;

endpackage

`default_nettype wire

//--- src/icache_way.sv
`timescale 1ns/1ps
`default_nettype none

module icache_way import icache_pkg::*; (
	input  wire logic clk,
	input  wire logic rst,
	input  way_cmd_t  cmd,
	input  wire logic wr,
	output logic      hit,
	output cache_line_u line
);

	logic [NUM_SETS-1:0] valid;
	logic [TAG_W-1:0]    tags [NUM_SETS];
	cache_line_u         lines [NUM_SETS];
	logic [INDEX_W-1:0]  index_q;
	cache_line_u         line_q;

	// Valid bits
	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= '0;
		end else if (cmd.invalidate_all) begin
			valid <= '0;
		end else if (wr) begin
			valid[cmd.index] <= 1'b1;
		end
	end

	// Set of the last read, used for the hit compare
	always_ff @(posedge clk) begin
		if (rst) begin
			index_q <= '0;
		end else if (cmd.rd) begin
			index_q <= cmd.index;
		end
	end

	always_ff @(posedge clk) begin
		if (wr) begin
			tags[cmd.index] <= cmd.tag;
			lines[cmd.index] <= cmd.line;
		end
	end

	// Synchronous line read
	always_ff @(posedge clk) begin
		if (cmd.rd)
			line_q <= lines[cmd.index];
	end

	assign hit = valid[index_q] && (tags[index_q] == cmd.tag);
	assign line = line_q;

endmodule

`default_nettype wire

//--- src/icache_way_select.sv
`timescale 1ns/1ps
`default_nettype none

module icache_way_select import icache_pkg::*; (
	input  wire logic                clk,
	input  wire logic                rst,
	input  wire logic [NUM_WAYS-1:0] way_hit,
	input  cache_line_u              way_lines [NUM_WAYS],
	input  cache_line_u              refill_line,
	input  wire logic                use_refill,
	input  wire logic [ADDR_W-1:0]   pc_q,
	input  wire logic                resp_valid_in,
	input  wire logic                resp_ready,
	output fetch_resp_t              resp
);

	cache_line_u hit_line;
	cache_line_u sel_line;
	fetch_resp_t live;
	fetch_resp_t resp_q;
	logic        held;

	// One-hot hit, so OR of masked lines
	always_comb begin
		hit_line = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (way_hit[w])
				hit_line = hit_line | way_lines[w];
		end
	end

	assign sel_line = use_refill ? refill_line : hit_line;

	always_comb begin
		live.pc = pc_q;
		live.inst = sel_line.words[pc_q[OFFSET_W-1:2]];
	end

	// Stalled response is frozen until it is taken
	always_ff @(posedge clk) begin
		if (rst) begin
			held <= 1'b0;
		end else if (resp_ready) begin
			held <= 1'b0;
		end else if (resp_valid_in) begin
			held <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (resp_valid_in && !held)
			resp_q <= live;
	end

	assign resp = held ? resp_q : live;

endmodule

`default_nettype wire

//--- src/icache_refill.sv
`timescale 1ns/1ps
`default_nettype none

module icache_refill import icache_pkg::*, axi_lite_pkg::*; (
	input  wire logic                       clk,
	input  wire logic                       rst,
	input  wire logic                       start,
	input  wire logic [ADDR_W-OFFSET_W-1:0] line_addr,
	output logic                            done,
	output cache_line_u                     line,
	output logic                            arvalid,
	input  wire logic                       arready,
	output axi_ar_t                         ar,
	input  wire logic                       rvalid,
	output logic                            rready,
	input  axi_r_t                          r
);

	typedef enum logic [1:0] {
		R_IDLE,
		R_ADDR,
		R_DATA,
		R_DONE
	} state_t;

	state_t                              state;
	logic [$clog2(BEATS_PER_LINE)-1:0]   beat_q;
	logic [ADDR_W-OFFSET_W-1:0]          line_addr_q;
	cache_line_u                         line_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= R_IDLE;
			beat_q <= '0;
		end else begin
			case (state)
				R_IDLE: begin
					if (start) begin
						beat_q <= '0;
						state <= R_ADDR;
					end
				end
				R_ADDR: begin
					if (arready)
						state <= R_DATA;
				end
				R_DATA: begin
					// One address in flight, next AR only after this beat
					if (rvalid) begin
						if (beat_q == $bits(beat_q)'(BEATS_PER_LINE - 1)) begin
							state <= R_DONE;
						end else begin
							beat_q <= beat_q + 1'b1;
							state <= R_ADDR;
						end
					end
				end
				R_DONE: state <= R_IDLE;
				default: state <= R_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if ((state == R_IDLE) && start)
			line_addr_q <= line_addr;
	end

	// RRESP not checked
	always_ff @(posedge clk) begin
		if ((state == R_DATA) && rvalid)
			line_q.beats[beat_q] <= r.data;
	end

	assign arvalid = (state == R_ADDR);
	assign rready = (state == R_DATA);
	assign done = (state == R_DONE);
	assign line = line_q;

	always_comb begin
		ar.addr = {line_addr_q, beat_q, 3'b000};
		ar.prot = PROT_INST;
	end

endmodule

`default_nettype wire

//--- src/icache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl import icache_pkg::*; (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire logic                 flush,
	input  wire logic                 req_valid,
	input  fetch_req_t                req,
	output logic                      req_ready,
	output logic                      resp_valid,
	input  wire logic                 resp_ready,
	output way_cmd_t                  way_cmd,
	output logic [NUM_WAYS-1:0]       way_wr,
	input  wire logic [NUM_WAYS-1:0]  way_hit,
	output logic                      refill_start,
	output logic [ADDR_W-OFFSET_W-1:0] refill_addr,
	input  wire logic                 refill_done,
	input  cache_line_u               refill_line,
	output logic [ADDR_W-1:0]         pc_q,
	output logic                      use_refill
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_LOOKUP,
		S_REFILL,
		S_RESP
	} state_t;

	state_t              state;
	state_t              state_next;
	logic [NUM_WAYS-1:0] victim;
	logic                hit_any;
	logic                resp_done;
	logic                accept;
	logic                fill;

	assign hit_any = |way_hit;

	// Hit answers straight from the lookup cycle, everything else from S_RESP
	assign resp_valid = (state == S_RESP) || ((state == S_LOOKUP) && hit_any);
	assign resp_done = resp_valid && resp_ready;

	// Flush only wins while nothing is held
	assign req_ready = ((state == S_IDLE) && !flush) || resp_done;
	assign accept = req_valid && req_ready;

	assign refill_start = (state == S_LOOKUP) && !hit_any;
	assign refill_addr = pc_q[ADDR_W-1:OFFSET_W];

	// Line arrives from refill; victim way takes it this cycle
	assign fill = (state == S_REFILL) && refill_done;
	assign way_wr = fill ? victim : '0;

	always_comb begin
		// New request indexes the arrays directly so the read lands at the accept edge
		way_cmd.index = accept ? req.pc[OFFSET_W +: INDEX_W] : pc_q[OFFSET_W +: INDEX_W];
		way_cmd.tag = pc_q[ADDR_W-1 -: TAG_W];
		way_cmd.rd = accept;
		way_cmd.invalidate_all = (state == S_IDLE) && flush;
		way_cmd.line = refill_line;
	end

	always_comb begin
		state_next = state;
		case (state)
			S_IDLE: begin
				if (accept)
					state_next = S_LOOKUP;
			end
			S_LOOKUP: begin
				if (!hit_any)
					state_next = S_REFILL;
				else if (resp_done)
					state_next = accept ? S_LOOKUP : S_IDLE;
				else
					state_next = S_RESP;
			end
			S_REFILL: begin
				if (refill_done)
					state_next = S_RESP;
			end
			S_RESP: begin
				if (resp_done)
					state_next = accept ? S_LOOKUP : S_IDLE;
			end
			default: state_next = S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			victim <= NUM_WAYS'(1);
			use_refill <= 1'b0;
		end else begin
			state <= state_next;
			if (fill) begin
				// Round robin, one step per miss
				victim <= {victim[NUM_WAYS-2:0], victim[NUM_WAYS-1]};
				use_refill <= 1'b1;
			end else if (accept) begin
				use_refill <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			pc_q <= req.pc;
	end

endmodule

`default_nettype wire

//--- src/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top import icache_pkg::*, axi_lite_pkg::*; (
	input  wire logic  clk,
	input  wire logic  rst,
	input  wire logic  flush,
	input  wire logic  req_valid,
	input  fetch_req_t req,
	output logic       req_ready,
	output logic       resp_valid,
	input  wire logic  resp_ready,
	output fetch_resp_t resp,
	output logic       arvalid,
	input  wire logic  arready,
	output axi_ar_t    ar,
	input  wire logic  rvalid,
	output logic       rready,
	input  axi_r_t     r
);

	way_cmd_t                   way_cmd;
	logic [NUM_WAYS-1:0]        way_wr;
	logic [NUM_WAYS-1:0]        way_hit;
	cache_line_u                way_lines [NUM_WAYS];
	logic                       refill_start;
	logic                       refill_done;
	logic [ADDR_W-OFFSET_W-1:0] refill_addr;
	cache_line_u                refill_line;
	logic [ADDR_W-1:0]          pc_q;
	logic                       use_refill;

	icache_ctrl u_ctrl (
		.clk          (clk),
		.rst          (rst),
		.flush        (flush),
		.req_valid    (req_valid),
		.req          (req),
		.req_ready    (req_ready),
		.resp_valid   (resp_valid),
		.resp_ready   (resp_ready),
		.way_cmd      (way_cmd),
		.way_wr       (way_wr),
		.way_hit      (way_hit),
		.refill_start (refill_start),
		.refill_addr  (refill_addr),
		.refill_done  (refill_done),
		.refill_line  (refill_line),
		.pc_q         (pc_q),
		.use_refill   (use_refill)
	);

	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
		icache_way u_way (
			.clk  (clk),
			.rst  (rst),
			.cmd  (way_cmd),
			.wr   (way_wr[w]),
			.hit  (way_hit[w]),
			.line (way_lines[w])
		);
	end

	icache_way_select u_way_select (
		.clk           (clk),
		.rst           (rst),
		.way_hit       (way_hit),
		.way_lines     (way_lines),
		.refill_line   (refill_line),
		.use_refill    (use_refill),
		.pc_q          (pc_q),
		.resp_valid_in (resp_valid),
		.resp_ready    (resp_ready),
		.resp          (resp)
	);

	icache_refill u_refill (
		.clk       (clk),
		.rst       (rst),
		.start     (refill_start),
		.line_addr (refill_addr),
		.done      (refill_done),
		.line      (refill_line),
		.arvalid   (arvalid),
		.arready   (arready),
		.ar        (ar),
		.rvalid    (rvalid),
		.rready    (rready),
		.r         (r)
	);

endmodule

`default_nettype wire

//--- dv/tb_axi_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem import axi_lite_pkg::*; #(
	parameter logic [31:0] SEED = 32'h1
) (
	input  wire logic    clk,
	input  wire logic    rst,
	input  wire logic    arvalid,
	output logic         arready,
	input  wire axi_ar_t ar,
	output logic         rvalid,
	input  wire logic    rready,
	output axi_r_t       r
);

	localparam logic [31:0] MEM_XOR = 32'h5a5a_c3c3;

	logic [31:0] rng;
	logic [1:0]  delay;
	logic        pending;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Every word holds its own address scrambled by a constant
	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		return addr ^ MEM_XOR;
	endfunction

	// Low word of the beat sits at the lower address
	function automatic logic [AXI_DATA_W-1:0] read_beat(input logic [31:0] addr);
		return {mem_word({addr[31:3], 3'b100}), mem_word({addr[31:3], 3'b000})};
	endfunction

	initial begin
		arready = 1'b0;
		rvalid = 1'b0;
		r = '0;
		rng = SEED;
		delay = 2'd0;
		pending = 1'b0;
		forever begin
			@(posedge clk);
			rng = xorshift32(rng);
			if (rst) begin
				arready <= 1'b0;
				rvalid <= 1'b0;
				pending = 1'b0;
				delay = 2'd0;
			end else if (arvalid && arready) begin
				arready <= 1'b0;
				r.data <= read_beat(ar.addr);
				r.resp <= 2'b00;
				pending = 1'b1;
				delay = rng[1:0];
			end else if (rvalid && rready) begin
				rvalid <= 1'b0;
				pending = 1'b0;
				delay = rng[3:2];
			end else if (delay != 2'd0) begin
				delay = delay - 2'd1;
			end else if (pending && !rvalid) begin
				rvalid <= 1'b1;
			end else if (!pending && arvalid && !arready) begin
				arready <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- dv/tb_icache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_icache import icache_pkg::*, axi_lite_pkg::*; ();

	localparam logic [31:0] SEED = 32'hb591_5442;
	localparam logic [31:0] MEM_XOR = 32'h5a5a_c3c3;
	localparam logic [31:0] BASE = 32'h0000_4000;
	localparam int NUM_REQ = 400;
	// Worst miss with full AXI delays plus stalls, gaps and flushes
	localparam int CYCLES_PER_REQ = 60;
	localparam int CYCLE_LIMIT = NUM_REQ * CYCLES_PER_REQ;

	typedef struct packed {
		logic [ADDR_W-1:0] pc;
		logic              hit;
		int                acc_cyc;
	} exp_t;

	logic        clk;
	logic        rst;
	logic        flush;
	logic        req_valid;
	fetch_req_t  req;
	logic        req_ready;
	logic        resp_valid;
	logic        resp_ready;
	fetch_resp_t resp;
	logic        arvalid;
	logic        arready;
	axi_ar_t     ar;
	logic        rvalid;
	logic        rready;
	axi_r_t      r;

	exp_t              exp_q [$];
	exp_t              head;
	logic [TAG_W-1:0]  m_tag [NUM_SETS][NUM_WAYS];
	bit [NUM_WAYS-1:0] m_valid [NUM_SETS];
	int                m_victim = 0;
	int                miss_count = 0;
	int                ar_count = 0;
	int                ar_in_req = 0;
	int                first_seen = -1;
	int                cyc = 0;
	logic              stalled = 1'b0;
	fetch_resp_t       held_resp;
	logic [31:0]       ar_expect;
	logic [31:0]       stim;
	logic [31:0]       ready_rng;
	logic [ADDR_W-1:0] pc;
	logic [ADDR_W-1:0] prev_pc;
	logic [1:0]        gap;

	icache_top dut (
		.clk        (clk),
		.rst        (rst),
		.flush      (flush),
		.req_valid  (req_valid),
		.req        (req),
		.req_ready  (req_ready),
		.resp_valid (resp_valid),
		.resp_ready (resp_ready),
		.resp       (resp),
		.arvalid    (arvalid),
		.arready    (arready),
		.ar         (ar),
		.rvalid     (rvalid),
		.rready     (rready),
		.r          (r)
	);

	tb_axi_mem #(.SEED(SEED ^ 32'h3c3c_5a5a)) u_mem (
		.clk     (clk),
		.rst     (rst),
		.arvalid (arvalid),
		.arready (arready),
		.ar      (ar),
		.rvalid  (rvalid),
		.rready  (rready),
		.r       (r)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		return addr ^ MEM_XOR;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "%s", why);
	endtask

	task automatic check(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			$display("Simulation failed");
			$fatal(1, "Check %s failed", name);
		end
	endtask

	// Reference tag store with a global round-robin victim
	task automatic predict(input logic [ADDR_W-1:0] addr, output logic hit);
		logic [INDEX_W-1:0] set;
		logic [TAG_W-1:0]   tag;
		set = addr[OFFSET_W +: INDEX_W];
		tag = addr[ADDR_W-1 -: TAG_W];
		hit = 1'b0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (m_valid[set][w] && (m_tag[set][w] == tag))
				hit = 1'b1;
		end
		if (!hit) begin
			m_tag[set][m_victim] = tag;
			m_valid[set][m_victim] = 1'b1;
			m_victim = (m_victim + 1) % NUM_WAYS;
			miss_count++;
		end
	endtask

	// Starts on a rising edge and returns on the edge that accepts the request
	task automatic drive_req(input logic [ADDR_W-1:0] addr);
		exp_t e;
		logic hit;
		req_valid <= 1'b1;
		req.pc <= addr;
		do
			@(negedge clk);
		while (!req_ready);
		predict(addr, hit);
		e.pc = addr;
		e.hit = hit;
		e.acc_cyc = cyc;
		exp_q.push_back(e);
		@(posedge clk);
	endtask

	// Flush pulse once every response is back and the cache is idle
	task automatic flush_cache();
		req_valid <= 1'b0;
		while (exp_q.size() != 0)
			@(posedge clk);
		flush <= 1'b1;
		@(posedge clk);
		flush <= 1'b0;
		for (int s = 0; s < NUM_SETS; s++)
			m_valid[s] = '0;
	endtask

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc > CYCLE_LIMIT)
			abort_run("Timeout: the fetch requests did not all complete in time");
	end

	// Random back-pressure on the response channel
	initial begin
		resp_ready = 1'b0;
		ready_rng = xorshift32(SEED ^ 32'h0f0f_0f0f);
		forever begin
			@(posedge clk);
			ready_rng = xorshift32(ready_rng);
			resp_ready <= (ready_rng[1:0] != 2'b00);
		end
	end

	always @(negedge clk) begin
		if (!rst) begin
			if (stalled) begin
				check("resp_valid_hold", 64'd1, 64'(resp_valid));
				check("resp_hold", 64'(held_resp), 64'(resp));
			end
			stalled = resp_valid && !resp_ready;
			held_resp = resp;

			if (arvalid && arready) begin
				if (exp_q.size() == 0) begin
					abort_run("AR transfer while no fetch request was outstanding");
				end else begin
					head = exp_q[0];
					ar_expect = {head.pc[ADDR_W-1:OFFSET_W], OFFSET_W'(0)} + 32'(8 * ar_in_req);
					check("ar_only_on_miss", 64'd0, 64'(head.hit));
					check("ar_addr", 64'(ar_expect), 64'(ar.addr));
					check("ar_prot", 64'(3'b100), 64'(ar.prot));
					ar_in_req++;
					ar_count++;
				end
			end

			if (resp_valid && (first_seen < 0))
				first_seen = cyc;
			if (resp_valid && resp_ready) begin
				if (exp_q.size() == 0) begin
					abort_run("Response seen with no fetch request outstanding");
				end else begin
					head = exp_q.pop_front();
					check("resp_pc", 64'(head.pc), 64'(resp.pc));
					check("resp_inst", 64'(mem_word(head.pc)), 64'(resp.inst));
					check("ar_per_fetch", head.hit ? 64'd0 : 64'd2, 64'(ar_in_req));
					// Hit is visible on the edge after the accept edge
					if (head.hit)
						check("hit_latency", 64'(head.acc_cyc + 1), 64'(first_seen));
					ar_in_req = 0;
					first_seen = -1;
				end
			end
		end
	end

	initial begin
		rst = 1'b1;
		flush = 1'b0;
		req_valid = 1'b0;
		req = '0;
		stim = SEED;
		prev_pc = BASE;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		for (int i = 0; i < NUM_REQ; i++) begin
			stim = xorshift32(stim);
			if (stim[23:21] == 3'd0)
				flush_cache();
			// PCs from a 1 KB window with some straight repeats
			if (stim[26:25] == 2'd0)
				pc = prev_pc;
			else
				pc = BASE | {22'd0, stim[9:2], 2'b00};
			prev_pc = pc;
			drive_req(pc);
			gap = stim[17:16];
			if (gap != 2'd0) begin
				req_valid <= 1'b0;
				repeat (gap) @(posedge clk);
			end
		end
		req_valid <= 1'b0;
		while (exp_q.size() != 0)
			@(posedge clk);
		$display("%0d fetches, %0d misses, %0d AR transfers", NUM_REQ, miss_count, ar_count);
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- icache_top.f
common/icache_pkg.sv
common/axi_lite_pkg.sv
src/icache_way.sv
src/icache_way_select.sv
src/icache_refill.sv
src/icache_ctrl.sv
src/icache_top.sv
dv/tb_axi_mem.sv
dv/tb_icache.sv

//--- run.sh
#!/usr/bin/env bash
# Build the icache testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps --top-module tb_icache -f icache_top.f; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_icache)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
	exit 0
fi

echo "Pass message not found in simulation output"
exit 1
